// File: logic/adc_trigger.sv
module adc_trigger (
   input  logic                     adc_clk_i,
   input  logic                     reset,
   input  logic                     cmd_arm_i,
   input  logic                     trigger_mode_i,
   input  logic                     trigger_now_i,
   input  openadc_pkg::trig_level_t trigger_level_i,
   input  openadc_pkg::count_t      trigger_offset_i,
   input  openadc_pkg::count_t      samples_i,
   input  openadc_pkg::adc_sample_t adc_sample_i,
   output openadc_pkg::adc_sample_t smp_data_o,
   output logic                     smp_valid_o,
   input  logic                     smp_ready_i,
   output logic [3:0]               status_o,
   output openadc_pkg::count_t      trigger_length_o
);
   import openadc_pkg::*;

   logic        arm_d_q;
   logic        armed_q;
   logic        triggered_q;
   logic        capturing_q;
   logic        done_q;
   logic        overrun_q;
   logic        dur_run_q;       // condition has held since the trigger
   count_t      off_left_q;
   count_t      cap_left_q;
   count_t      dur_q;
   adc_sample_t smp_data_q;
   logic        smp_valid_q;
   logic        level_hit;
   logic        arm_rise;
   logic        fire;
   logic        delaying;
   logic        start;
   logic        emit;
   logic        finish;
   logic        run_now;

   assign level_hit = trigger_mode_i ? ({2'b00, adc_sample_i} >= trigger_level_i)
                                     : ({2'b00, adc_sample_i} < trigger_level_i);

   assign arm_rise = cmd_arm_i & ~arm_d_q;
   assign fire     = armed_q & cmd_arm_i & ~triggered_q & (trigger_now_i | level_hit);
   assign delaying = armed_q & cmd_arm_i & triggered_q & ~capturing_q & ~done_q;
   // first streamed sample sits offset edges after the trigger sample
   assign start    = (fire && trigger_offset_i == '0) || (delaying && off_left_q == count_t'(1));
   assign emit     = (start && samples_i != '0) || (armed_q && cmd_arm_i && capturing_q);
   assign finish   = (start && samples_i <= count_t'(1)) ||
                     (capturing_q && cap_left_q == count_t'(1));
   assign run_now  = fire ? level_hit : (dur_run_q & level_hit);

   always_ff @(posedge adc_clk_i) begin
      if (reset) begin
         arm_d_q     <= 1'b0;
         armed_q     <= 1'b0;
         triggered_q <= 1'b0;
         capturing_q <= 1'b0;
         done_q      <= 1'b0;
         overrun_q   <= 1'b0;
         dur_run_q   <= 1'b0;
         dur_q       <= '0;
         smp_valid_q <= 1'b0;
      end else begin
         arm_d_q     <= cmd_arm_i;
         smp_valid_q <= emit;
         if (smp_valid_q && !smp_ready_i)
            overrun_q <= 1'b1;   // sink missed a sample
         if (!cmd_arm_i) begin
            armed_q     <= 1'b0;
            capturing_q <= 1'b0;
            dur_run_q   <= 1'b0;
         end else if (arm_rise) begin
            armed_q     <= 1'b1;
            triggered_q <= 1'b0;
            capturing_q <= 1'b0;
            done_q      <= 1'b0;
            overrun_q   <= 1'b0;
            dur_run_q   <= 1'b0;
            dur_q       <= '0;
         end else begin
            if (fire)
               triggered_q <= 1'b1;
            if (start)
               capturing_q <= (samples_i > count_t'(1));
            if (finish) begin
               capturing_q <= 1'b0;
               done_q      <= 1'b1;
            end
            if (fire || delaying || capturing_q)
               dur_run_q <= run_now;
            if (emit && run_now)
               dur_q <= dur_q + count_t'(1);   // only streamed samples count
         end
      end
   end

   always_ff @(posedge adc_clk_i) begin
      if (fire)
         off_left_q <= trigger_offset_i;
      else if (delaying)
         off_left_q <= off_left_q - count_t'(1);
      if (start)
         cap_left_q <= samples_i - count_t'(1);
      else if (capturing_q)
         cap_left_q <= cap_left_q - count_t'(1);
      if (emit)
         smp_data_q <= adc_sample_i;
   end

   assign smp_data_o       = smp_data_q;
   assign smp_valid_o      = smp_valid_q;
   assign status_o         = {overrun_q, done_q, triggered_q, armed_q};
   assign trigger_length_o = dur_q;

   // samples only leave while the arm is still held
   a_valid_needs_arm: assert property (@(posedge adc_clk_i) disable iff (reset)
      smp_valid_o |-> armed_q);

endmodule

// File: logic/host_reg_bridge.sv
module host_reg_bridge (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  openadc_pkg::reg_byte_t cmd_data_i,
   input  logic                   cmd_valid_i,
   output logic                   cmd_ready_o,
   output openadc_pkg::reg_byte_t rd_data_o,
   output logic                   rd_valid_o,
   input  logic                   rd_ready_i,
   output openadc_pkg::reg_addr_t reg_address_o,
   output openadc_pkg::byte_cnt_t reg_bytecnt_o,
   output openadc_pkg::reg_byte_t reg_datai_o,
   output logic                   reg_write_o,
   output logic                   reg_read_o,
   input  openadc_pkg::reg_byte_t reg_datao_i
);
   import openadc_pkg::*;

   bridge_state_t state_q;
   reg_addr_t     addr_q;
   logic          is_read_q;
   logic [7:0]    remain_q;       // bytes left in this command
   byte_cnt_t     idx_q;          // index of the next bus stroke
   reg_byte_t     wr_data_q;
   logic          wr_pulse_q;
   reg_byte_t     rd_data_q;
   logic          rd_valid_q;
   logic          cmd_fire;
   logic          rd_fire;

   assign cmd_ready_o = (state_q != bridge_read);  // host waits out a read
   assign cmd_fire    = cmd_valid_i & cmd_ready_o;
   assign rd_fire     = rd_valid_q & rd_ready_i;

   // byte 0 is fetched as the length goes in and byte k as byte k-1 leaves
   assign reg_read_o = (state_q == bridge_len && cmd_fire && is_read_q && cmd_data_i != 8'd0) ||
                       (state_q == bridge_read && rd_fire && remain_q != 8'd1);

   assign reg_write_o   = wr_pulse_q;   // one cycle after the byte is taken
   assign reg_address_o = addr_q;
   assign reg_bytecnt_o = idx_q;
   assign reg_datai_o   = wr_data_q;
   assign rd_data_o     = rd_data_q;
   assign rd_valid_o    = rd_valid_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q    <= bridge_idle;
         is_read_q  <= 1'b0;
         remain_q   <= 8'd0;
         idx_q      <= '0;
         wr_pulse_q <= 1'b0;
         rd_valid_q <= 1'b0;
      end else begin
         wr_pulse_q <= 1'b0;
         if (reg_write_o || reg_read_o)
            idx_q <= idx_q + 1'b1;
         case (state_q)
            bridge_idle: begin
               if (cmd_fire) begin
                  is_read_q <= cmd_data_i[7];   // bit 7 set means read
                  idx_q     <= '0;
                  state_q   <= bridge_len;
               end
            end
            bridge_len: begin
               if (cmd_fire) begin
                  remain_q <= cmd_data_i;
                  if (cmd_data_i == 8'd0) begin
                     state_q <= bridge_idle;   // empty command
                  end else if (is_read_q) begin
                     rd_valid_q <= 1'b1;
                     state_q    <= bridge_read;
                  end else begin
                     state_q <= bridge_write;
                  end
               end
            end
            bridge_write: begin
               if (cmd_fire) begin
                  wr_pulse_q <= 1'b1;
                  remain_q   <= remain_q - 8'd1;
                  if (remain_q == 8'd1)
                     state_q <= bridge_idle;
               end
            end
            bridge_read: begin
               if (rd_fire) begin
                  remain_q <= remain_q - 8'd1;
                  if (remain_q == 8'd1) begin
                     rd_valid_q <= 1'b0;
                     state_q    <= bridge_idle;
                  end
               end
            end
            default: state_q <= bridge_idle;
         endcase
      end
   end

   // header address, write byte and fetched read byte
   always_ff @(posedge clk_usb) begin
      if (state_q == bridge_idle && cmd_fire)
         addr_q <= cmd_data_i[5:0];
      if (state_q == bridge_write && cmd_fire)
         wr_data_q <= cmd_data_i;
      if (reg_read_o)
         rd_data_q <= reg_datao_i;   // held while the host stalls
   end

   // a delayed write pulse must never land on a read fetch
   a_no_rw_overlap: assert property (@(posedge clk_usb) disable iff (reset)
      !(reg_write_o && reg_read_o));

endmodule

// File: logic/openadc_defs.svh
`ifndef OPENADC_DEFS_SVH
`define OPENADC_DEFS_SVH

// register map, 6-bit addresses
`define GAIN_ADDR              6'd0   // 1 byte
`define SETTINGS_ADDR          6'd1   // 1 byte
`define STATUS_ADDR            6'd2   // 1 byte, read only
`define ECHO_ADDR              6'd3   // 4 bytes
`define OFFSET_ADDR            6'd4   // 4 bytes
`define SAMPLES_ADDR           6'd5   // 4 bytes
`define TRIGGER_DUR_ADDR       6'd6   // 4 bytes, read only
`define VERSION_ADDR           6'd7   // 2 bytes, read only
`define ADC_TRIGGER_LEVEL_ADDR 6'd8   // 2 bytes, upper nibble unused
`define SYSTEMCLK_ADDR         6'd9   // 4 bytes, read only

// version word is {hw type, hw ver, 4'h0, register version}
`define HW_TYPE                5'd2
`define HW_VER                 3'd1
`define REGISTER_VERSION       4'd1

// frequency of clk_usb in Hz
`define SYSTEM_CLK             32'd96000000

// width of the byte index on the register bus
`define BYTECNT_SIZE           7

// settings register bit positions
`define SET_SOFT_RESET         0
`define SET_TRIG_RISING        2
`define SET_ARM                3
`define SET_TRIG_NOW           6

// reset values
`define SETTINGS_DEFAULT       8'h04  // rising edge trigger
`define SAMPLES_DEFAULT        32'd16

// status register bit positions
`define STAT_ARMED             0
`define STAT_TRIGGERED         1
`define STAT_DONE              2
`define STAT_OVERRUN           3

`endif

// File: logic/openadc_pkg.sv
`include "openadc_defs.svh"

package openadc_pkg;

   // register bus
   typedef logic [5:0]                 reg_addr_t;
   typedef logic [7:0]                 reg_byte_t;
   typedef logic [`BYTECNT_SIZE-1:0]   byte_cnt_t;   // byte index inside a register

   // ADC side
   typedef logic [9:0]                 adc_sample_t;
   typedef logic [11:0]                trig_level_t;
   typedef logic [31:0]                count_t;      // offset, sample count, duration

   // host command parser
   typedef enum logic [1:0] {
      bridge_idle,    // waiting for a header byte
      bridge_len,     // waiting for the length byte
      bridge_write,   // taking data bytes
      bridge_read     // returning data bytes
   } bridge_state_t;

endpackage

// File: logic/openadc_regs.sv
`include "openadc_defs.svh"

module openadc_regs (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic                     adc_clk_i,
   input  openadc_pkg::reg_addr_t   reg_address_i,
   input  openadc_pkg::byte_cnt_t   reg_bytecnt_i,
   input  openadc_pkg::reg_byte_t   reg_datai_i,
   input  logic                     reg_write_i,
   input  logic                     reg_read_i,
   output openadc_pkg::reg_byte_t   reg_datao_o,
   output openadc_pkg::reg_byte_t   gain_o,
   output logic                     cmd_arm_adc_o,
   output logic                     trigger_mode_o,
   output logic                     trigger_now_o,
   output openadc_pkg::count_t      trigger_offset_o,
   output openadc_pkg::count_t      samples_o,
   output openadc_pkg::trig_level_t trigger_level_o,
   input  logic [3:0]               status_adc_i,
   input  openadc_pkg::count_t      trigger_length_i
);
   import openadc_pkg::*;

   logic        rst;               // board reset or soft reset
   reg_byte_t   gain_q;
   reg_byte_t   settings_q;
   count_t      echo_q;
   count_t      offset_q;
   count_t      samples_q;
   trig_level_t level_q;
   logic [3:0]  arm_pipe_q;        // adc_clk_i domain
   logic [3:0]  status_meta_q;
   logic [3:0]  status_q;
   logic [15:0] version_word;
   count_t      rd_word;
   logic [1:0]  sel;
   logic        byte_ok;

   assign rst     = reset | settings_q[`SET_SOFT_RESET];
   assign sel     = reg_bytecnt_i[1:0];
   assign byte_ok = (reg_bytecnt_i < byte_cnt_t'(4));   // no register is wider than 4 bytes

   assign gain_o           = gain_q;
   assign trigger_mode_o   = settings_q[`SET_TRIG_RISING];
   assign trigger_now_o    = settings_q[`SET_TRIG_NOW];
   assign trigger_offset_o = offset_q;
   assign samples_o        = samples_q;
   assign trigger_level_o  = level_q;

   assign version_word = {`HW_TYPE, `HW_VER, 4'h0, `REGISTER_VERSION};

   always_ff @(posedge clk_usb) begin
      if (rst) begin
         gain_q     <= 8'h00;
         settings_q <= `SETTINGS_DEFAULT;   // also drops the soft reset bit
         echo_q     <= '0;
         offset_q   <= '0;
         samples_q  <= `SAMPLES_DEFAULT;
         level_q    <= '0;
      end else if (reg_write_i && byte_ok) begin
         case (reg_address_i)
            `GAIN_ADDR: begin
               if (sel == 2'd0)
                  gain_q <= reg_datai_i;
            end
            `SETTINGS_ADDR: begin
               if (sel == 2'd0)
                  settings_q <= reg_datai_i;
            end
            `ECHO_ADDR:    echo_q[{sel, 3'b000} +: 8]    <= reg_datai_i;
            `OFFSET_ADDR:  offset_q[{sel, 3'b000} +: 8]  <= reg_datai_i;
            `SAMPLES_ADDR: samples_q[{sel, 3'b000} +: 8] <= reg_datai_i;
            `ADC_TRIGGER_LEVEL_ADDR: begin
               if (sel == 2'd0)
                  level_q[7:0] <= reg_datai_i;
               else if (sel == 2'd1)
                  level_q[11:8] <= reg_datai_i[3:0];   // top nibble dropped
            end
            default: ;
         endcase
      end
   end

   // whole register word, byte picked below
   always_comb begin
      case (reg_address_i)
         `GAIN_ADDR:              rd_word = {24'h0, gain_q};
         `SETTINGS_ADDR:          rd_word = {24'h0, settings_q};
         `STATUS_ADDR:            rd_word = {28'h0, status_q};
         `ECHO_ADDR:              rd_word = echo_q;
         `OFFSET_ADDR:            rd_word = offset_q;
         `SAMPLES_ADDR:           rd_word = samples_q;
         `TRIGGER_DUR_ADDR:       rd_word = trigger_length_i;   // stable once done
         `VERSION_ADDR:           rd_word = {16'h0, version_word};
         `ADC_TRIGGER_LEVEL_ADDR: rd_word = {20'h0, level_q};
         `SYSTEMCLK_ADDR:         rd_word = `SYSTEM_CLK;
         default:                 rd_word = '0;
      endcase
   end

   assign reg_datao_o = (reg_read_i && byte_ok) ? rd_word[{sel, 3'b000} +: 8] : 8'h00;

   // arm crosses into the sample clock, four stages
   always_ff @(posedge adc_clk_i) begin
      if (rst)
         arm_pipe_q <= '0;
      else
         arm_pipe_q <= {arm_pipe_q[2:0], settings_q[`SET_ARM]};
   end
   assign cmd_arm_adc_o = arm_pipe_q[3];

   // status bits back into clk_usb
   always_ff @(posedge clk_usb) begin
      if (rst) begin
         status_meta_q <= '0;
         status_q      <= '0;
      end else begin
         status_meta_q <= status_adc_i;
         status_q      <= status_meta_q;
      end
   end

endmodule

// File: logic/openadc_top.sv
module openadc_top (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic                     adc_clk_i,
   input  openadc_pkg::adc_sample_t adc_sample_i,
   input  openadc_pkg::reg_byte_t   cmd_data_i,
   input  logic                     cmd_valid_i,
   output logic                     cmd_ready_o,
   output openadc_pkg::reg_byte_t   rd_data_o,
   output logic                     rd_valid_o,
   input  logic                     rd_ready_i,
   output openadc_pkg::adc_sample_t smp_data_o,
   output logic                     smp_valid_o,
   input  logic                     smp_ready_i,
   output openadc_pkg::reg_byte_t   gain_o
);
   import openadc_pkg::*;

   reg_addr_t   reg_address;
   byte_cnt_t   reg_bytecnt;
   reg_byte_t   reg_datai;
   reg_byte_t   reg_datao;
   logic        reg_write;
   logic        reg_read;
   logic        cmd_arm_adc;
   logic        trigger_mode;
   logic        trigger_now;
   count_t      trigger_offset;
   count_t      samples;
   trig_level_t trigger_level;
   logic [3:0]  status_adc;
   count_t      trigger_length;
   logic [1:0]  adc_reset_q;     // reset brought into adc_clk_i

   always_ff @(posedge adc_clk_i) begin
      adc_reset_q <= {adc_reset_q[0], reset};
   end

   host_reg_bridge u_bridge (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .cmd_data_i    (cmd_data_i),
      .cmd_valid_i   (cmd_valid_i),
      .cmd_ready_o   (cmd_ready_o),
      .rd_data_o     (rd_data_o),
      .rd_valid_o    (rd_valid_o),
      .rd_ready_i    (rd_ready_i),
      .reg_address_o (reg_address),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_datai_o   (reg_datai),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read),
      .reg_datao_i   (reg_datao)
   );

   openadc_regs u_regs (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .adc_clk_i        (adc_clk_i),
      .reg_address_i    (reg_address),
      .reg_bytecnt_i    (reg_bytecnt),
      .reg_datai_i      (reg_datai),
      .reg_write_i      (reg_write),
      .reg_read_i       (reg_read),
      .reg_datao_o      (reg_datao),
      .gain_o           (gain_o),
      .cmd_arm_adc_o    (cmd_arm_adc),
      .trigger_mode_o   (trigger_mode),
      .trigger_now_o    (trigger_now),
      .trigger_offset_o (trigger_offset),
      .samples_o        (samples),
      .trigger_level_o  (trigger_level),
      .status_adc_i     (status_adc),
      .trigger_length_i (trigger_length)
   );

   adc_trigger u_trigger (
      .adc_clk_i        (adc_clk_i),
      .reset            (adc_reset_q[1]),
      .cmd_arm_i        (cmd_arm_adc),
      .trigger_mode_i   (trigger_mode),
      .trigger_now_i    (trigger_now),
      .trigger_level_i  (trigger_level),
      .trigger_offset_i (trigger_offset),
      .samples_i        (samples),
      .adc_sample_i     (adc_sample_i),
      .smp_data_o       (smp_data_o),
      .smp_valid_o      (smp_valid_o),
      .smp_ready_i      (smp_ready_i),
      .status_o         (status_adc),
      .trigger_length_o (trigger_length)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_openadc -f sources.f

result=$(./obj_dir/Vtb_openadc 2>&1) || true
echo "$result"

if echo "$result" | grep -q "Test completed successfully"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: sources.f
+incdir+logic
logic/openadc_pkg.sv
logic/host_reg_bridge.sv
logic/openadc_regs.sv
logic/adc_trigger.sv
logic/openadc_top.sv
testbench/tb_openadc.sv

// File: testbench/tb_openadc.sv
`include "openadc_defs.svh"

module tb_openadc;
   import openadc_pkg::*;

   localparam int        wait_limit     = 4000;   // clk_usb cycles per wait
   localparam int        poll_limit     = 200;    // status reads per poll
   localparam reg_byte_t bit_soft_reset = 8'h01 << `SET_SOFT_RESET;
   localparam reg_byte_t bit_rising     = 8'h01 << `SET_TRIG_RISING;
   localparam reg_byte_t bit_arm        = 8'h01 << `SET_ARM;
   localparam reg_byte_t bit_now        = 8'h01 << `SET_TRIG_NOW;
   localparam reg_byte_t stat_armed     = 8'h01 << `STAT_ARMED;
   localparam reg_byte_t stat_done      = 8'h01 << `STAT_DONE;
   localparam reg_byte_t stat_overrun   = 8'h01 << `STAT_OVERRUN;

   logic        clk_usb;
   logic        reset;
   logic        adc_clk_i;
   adc_sample_t adc_sample_i = '0;
   reg_byte_t   cmd_data_i;
   logic        cmd_valid_i;
   logic        cmd_ready_o;
   reg_byte_t   rd_data_o;
   logic        rd_valid_o;
   logic        rd_ready_i;
   adc_sample_t smp_data_o;
   logic        smp_valid_o;
   logic        smp_ready_i;
   reg_byte_t   gain_o;

   integer      seed;
   logic        use_ramp;              // ramp restarts from 0 when this rises
   adc_sample_t ramp = '0;
   adc_sample_t captured[$];          // every sample offered on the stream

   openadc_top u_openadc_top (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .adc_clk_i    (adc_clk_i),
      .adc_sample_i (adc_sample_i),
      .cmd_data_i   (cmd_data_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .rd_data_o    (rd_data_o),
      .rd_valid_o   (rd_valid_o),
      .rd_ready_i   (rd_ready_i),
      .smp_data_o   (smp_data_o),
      .smp_valid_o  (smp_valid_o),
      .smp_ready_i  (smp_ready_i),
      .gain_o       (gain_o)
   );

   initial clk_usb = 1'b0;
   always #50 clk_usb = ~clk_usb;

   initial adc_clk_i = 1'b0;
   always #35 adc_clk_i = ~adc_clk_i;   // rising edges never meet a clk_usb edge

   // one new sample per adc edge from the random source or the ramp
   always @(negedge adc_clk_i) begin
      if (use_ramp) begin
         adc_sample_i <= ramp;
         ramp         <= ramp + 10'd1;
      end else begin
         adc_sample_i <= adc_sample_t'($random(seed));
         ramp         <= '0;
      end
   end

   always @(negedge adc_clk_i) begin
      if (smp_valid_o)
         captured.push_back(smp_data_o);
   end

   task automatic check_value(input count_t actual, input count_t expected, input string what);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
         $display("Test failed");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at time %0t while waiting for %s", $time, what);
      $display("Test failed");
      $fatal(1, "wait limit exceeded");
   endtask

   task automatic send_byte(input reg_byte_t data);
      int waited;
      waited = 0;
      @(negedge clk_usb);
      cmd_data_i  = data;
      cmd_valid_i = 1'b1;
      while (!cmd_ready_o) begin
         @(negedge clk_usb);
         waited++;
         if (waited > wait_limit)
            report_timeout("the bridge to take a command byte");
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input int nbytes, input count_t value);
      send_byte({2'b00, addr});
      send_byte(reg_byte_t'(nbytes));
      for (int i = 0; i < nbytes; i++)
         send_byte(value[8*i +: 8]);   // least significant byte first
      @(negedge clk_usb);
      cmd_valid_i = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, input int nbytes, input logic stall,
                           output count_t value);
      int          got;
      int          waited;
      logic [31:0] coin;
      send_byte({2'b10, addr});
      send_byte(reg_byte_t'(nbytes));
      value  = '0;
      got    = 0;
      waited = 0;
      while (got < nbytes) begin
         @(negedge clk_usb);
         cmd_valid_i = 1'b0;
         coin        = $random(seed);
         rd_ready_i  = stall ? coin[0] : 1'b1;
         if (rd_valid_o && rd_ready_i) begin
            value[8*got +: 8] = rd_data_o;   // moves on the next edge
            got++;
         end
         waited++;
         if (waited > wait_limit)
            report_timeout("read bytes from the bridge");
      end
      @(negedge clk_usb);
      rd_ready_i = 1'b0;
   endtask

   task automatic poll_status(input reg_byte_t mask, input reg_byte_t want, input string what,
                              output reg_byte_t status);
      count_t word;
      int     polls;
      polls = 0;
      read_reg(`STATUS_ADDR, 1, 1'b0, word);
      while ((word[7:0] & mask) != want) begin
         polls++;
         if (polls > poll_limit)
            report_timeout(what);
         read_reg(`STATUS_ADDR, 1, 1'b0, word);
      end
      status = word[7:0];
   endtask

   task automatic wait_first_sample(input string what);
      int waited;
      waited = 0;
      while (captured.size() == 0) begin
         @(negedge clk_usb);
         waited++;
         if (waited > wait_limit)
            report_timeout(what);
      end
   endtask

   // arm low again so the next capture sees a fresh rising arm
   task automatic disarm();
      reg_byte_t status;
      write_reg(`SETTINGS_ADDR, 1, count_t'(bit_rising));
      poll_status(stat_armed, 8'h00, "the armed bit to clear", status);
   endtask

   task automatic test_reset_defaults();
      count_t word;
      check_value(count_t'(cmd_ready_o), 32'd1, "cmd_ready_o after reset");
      check_value(count_t'(rd_valid_o), 32'd0, "rd_valid_o after reset");
      check_value(count_t'(smp_valid_o), 32'd0, "smp_valid_o after reset");
      read_reg(`SETTINGS_ADDR, 1, 1'b0, word);
      check_value(word, 32'h04, "settings default");
      read_reg(`SAMPLES_ADDR, 4, 1'b0, word);
      check_value(word, 32'd16, "samples default");
      read_reg(`VERSION_ADDR, 2, 1'b0, word);
      check_value(word, (count_t'(`HW_TYPE) << 11) | (count_t'(`HW_VER) << 8) |
                  count_t'(`REGISTER_VERSION), "version word");
      read_reg(`SYSTEMCLK_ADDR, 4, 1'b0, word);
      check_value(word, `SYSTEM_CLK, "system clock");
      read_reg(6'd20, 4, 1'b0, word);
      check_value(word, 32'd0, "unknown address");
   endtask

   task automatic test_echo();
      count_t pattern;
      count_t word;
      pattern = $random(seed);
      write_reg(`ECHO_ADDR, 4, pattern);
      read_reg(`ECHO_ADDR, 4, 1'b0, word);
      check_value(word, pattern, "echo read");
      read_reg(`ECHO_ADDR, 4, 1'b1, word);
      check_value(word, pattern, "echo read with stalls");
   endtask

   task automatic test_forced_trigger();
      reg_byte_t status;
      write_reg(`SAMPLES_ADDR, 4, 32'd8);
      write_reg(`OFFSET_ADDR, 4, 32'd0);
      captured.delete();
      write_reg(`SETTINGS_ADDR, 1, count_t'(bit_rising | bit_arm | bit_now));
      wait_first_sample("the first forced sample");
      poll_status(stat_done, stat_done, "done after forced trigger", status);
      check_value(count_t'(captured.size()), 32'd8, "forced capture length");
      check_value(count_t'(status & stat_overrun), 32'd0, "overrun with sink ready");
      disarm();
   endtask

   task automatic test_level_trigger();
      reg_byte_t status;
      count_t    word;
      count_t    level;
      count_t    offset;
      count_t    count;
      level  = 32'd100;
      offset = 32'd5;
      count  = 32'd10;
      write_reg(`ADC_TRIGGER_LEVEL_ADDR, 2, level);
      write_reg(`OFFSET_ADDR, 4, offset);
      write_reg(`SAMPLES_ADDR, 4, count);
      captured.delete();
      use_ramp = 1'b1;
      write_reg(`SETTINGS_ADDR, 1, count_t'(bit_rising | bit_arm));
      wait_first_sample("the first sample after the level trigger");
      poll_status(stat_done, stat_done, "done after level trigger", status);
      check_value(count_t'(captured.size()), count, "level capture length");
      // the ramp meets the level at the trigger sample and streams offset edges later
      for (int i = 0; i < captured.size(); i++)
         check_value(count_t'(captured[i]), level + offset + count_t'(i),
                     $sformatf("ramp sample %0d", i));
      read_reg(`TRIGGER_DUR_ADDR, 4, 1'b0, word);
      check_value(word, count, "trigger duration");
      use_ramp = 1'b0;
      disarm();
   endtask

   task automatic test_overrun();
      reg_byte_t status;
      write_reg(`SAMPLES_ADDR, 4, 32'd8);
      write_reg(`OFFSET_ADDR, 4, 32'd0);
      @(negedge adc_clk_i);
      smp_ready_i = 1'b0;
      captured.delete();
      write_reg(`SETTINGS_ADDR, 1, count_t'(bit_rising | bit_arm | bit_now));
      wait_first_sample("a sample while the sink stalls");
      poll_status(stat_done, stat_done, "done with the sink stalled", status);
      check_value(count_t'(status & stat_overrun), count_t'(stat_overrun), "overrun bit");
      @(negedge adc_clk_i);
      smp_ready_i = 1'b1;
      disarm();
   endtask

   task automatic test_soft_reset();
      count_t word;
      write_reg(`GAIN_ADDR, 1, 32'h5a);
      write_reg(`OFFSET_ADDR, 4, 32'h0000_0123);
      read_reg(`GAIN_ADDR, 1, 1'b0, word);
      check_value(word, 32'h5a, "gain before soft reset");
      check_value(count_t'(gain_o), 32'h5a, "gain_o before soft reset");
      write_reg(`SETTINGS_ADDR, 1, count_t'(bit_soft_reset));
      read_reg(`GAIN_ADDR, 1, 1'b0, word);
      check_value(word, 32'h0, "gain after soft reset");
      check_value(count_t'(gain_o), 32'h0, "gain_o after soft reset");
      read_reg(`SETTINGS_ADDR, 1, 1'b0, word);
      check_value(word, 32'h04, "settings after soft reset");
      read_reg(`SAMPLES_ADDR, 4, 1'b0, word);
      check_value(word, 32'd16, "samples after soft reset");
      read_reg(`OFFSET_ADDR, 4, 1'b0, word);
      check_value(word, 32'd0, "offset after soft reset");
      read_reg(`ADC_TRIGGER_LEVEL_ADDR, 2, 1'b0, word);
      check_value(word, 32'd0, "level after soft reset");
      read_reg(`ECHO_ADDR, 4, 1'b0, word);
      check_value(word, 32'd0, "echo after soft reset");
   endtask

   initial begin
      seed        = 32'h313e;
      reset       = 1'b1;
      cmd_data_i  = 8'h00;
      cmd_valid_i = 1'b0;
      rd_ready_i  = 1'b0;
      smp_ready_i = 1'b1;
      use_ramp    = 1'b0;
      repeat (5) @(negedge clk_usb);
      reset = 1'b0;
      test_reset_defaults();
      test_echo();
      test_forced_trigger();
      test_level_trigger();
      test_overrun();
      test_soft_reset();
      $display("Test completed successfully");
      $finish;
   end

endmodule
